/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;      // data, address or instruction
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_mask_t; // one bit per byte lane
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [1:0]  wb_sel_t;

  // opcodes of the supported subset
  localparam opcode_t OPC_OP_IMM = 7'b001_0011; // every op-imm runs as addi
  localparam opcode_t OPC_LUI    = 7'b011_0111;
  localparam opcode_t OPC_AUIPC  = 7'b001_0111;
  localparam opcode_t OPC_JAL    = 7'b110_1111;
  localparam opcode_t OPC_JALR   = 7'b110_0111;
  localparam opcode_t OPC_LOAD   = 7'b000_0011;
  localparam opcode_t OPC_STORE  = 7'b010_0011;
  localparam opcode_t OPC_SYSTEM = 7'b111_0011;

  // load and store widths
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  localparam word_t RESET_PC = 32'h8000_0000;
  localparam word_t PC_STEP  = 32'd4;
  localparam int    NUM_REGS = 32;

  // write-back source
  localparam wb_sel_t WB_ADDER = 2'd0;
  localparam wb_sel_t WB_LINK  = 2'd1; // pc + 4
  localparam wb_sel_t WB_LOAD  = 2'd2;

  typedef struct packed {
    logic    reg_wen;
    logic    mem_read;
    logic    mem_write;
    logic    src1_pc;   // adder takes pc instead of rs1
    logic    pc_jump;   // next pc comes from the adder
    wb_sel_t wb_sel;
    logic    halt;
    funct3_t funct3;
    word_t   imm;
  } ctrl_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;  // already shifted into its lanes
    byte_mask_t wmask;
    logic       read;
    logic       write;
  } dmem_req_t;

endpackage

`default_nettype wire

/* src/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  rv_pkg::word_t inst,
  output rv_pkg::ctrl_t ctrl
);

  rv_pkg::opcode_t opcode;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_s;
  rv_pkg::word_t   imm_u;
  rv_pkg::word_t   imm_j;

  assign opcode = inst[6:0];

  // sign extended immediates, u keeps the upper twenty bits
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.wb_sel = rv_pkg::WB_ADDER;
    ctrl.funct3 = inst[14:12];
    case (opcode)
      rv_pkg::OPC_OP_IMM: begin
        ctrl.reg_wen = 1'b1;
        ctrl.imm     = imm_i;
      end
      rv_pkg::OPC_LUI: begin
        ctrl.reg_wen = 1'b1; // rs1 forced to x0 in the top
        ctrl.imm     = imm_u;
      end
      rv_pkg::OPC_AUIPC: begin
        ctrl.reg_wen = 1'b1;
        ctrl.src1_pc = 1'b1;
        ctrl.imm     = imm_u;
      end
      rv_pkg::OPC_JAL: begin
        ctrl.reg_wen = 1'b1;
        ctrl.src1_pc = 1'b1;
        ctrl.pc_jump = 1'b1;
        ctrl.wb_sel  = rv_pkg::WB_LINK;
        ctrl.imm     = imm_j;
      end
      rv_pkg::OPC_JALR: begin
        ctrl.reg_wen = 1'b1;
        ctrl.pc_jump = 1'b1;
        ctrl.wb_sel  = rv_pkg::WB_LINK;
        ctrl.imm     = imm_i;
      end
      rv_pkg::OPC_LOAD: begin
        ctrl.reg_wen  = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.wb_sel   = rv_pkg::WB_LOAD;
        ctrl.imm      = imm_i;
      end
      rv_pkg::OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.imm       = imm_s;
      end
      rv_pkg::OPC_SYSTEM: ctrl.halt = (inst[31:7] == {12'h001, 13'd0}); // ebreak only
      default:            ctrl.reg_wen = 1'b0; // unknown opcode, no effect
    endcase
  end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::reg_addr_t rd_addr,
  input  logic              wen,
  input  rv_pkg::word_t     wdata,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  rv_pkg::word_t regs [rv_pkg::NUM_REGS];

  always_ff @(posedge clk) begin
    if (wen && (rd_addr != '0)) begin
      regs[rd_addr] <= wdata;
    end
  end

  // combinational reads, a same-cycle write is not forwarded
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* src/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
  input  logic          clk,
  input  logic          reset,
  input  logic          pc_jump,
  input  rv_pkg::word_t jump_target,
  output rv_pkg::word_t pc
);

  rv_pkg::word_t next_pc;

  // jalr target drops bit 0, jal target is already even
  assign next_pc = pc_jump ? {jump_target[31:1], 1'b0} : pc + rv_pkg::PC_STEP;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= rv_pkg::RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // every target the core produces must keep the pc on a word boundary
  a_pc_aligned: assert property (@(posedge clk) !reset |=> pc[1:0] == 2'b00)
    else $error("pc_unit: pc %h not word aligned", pc);

endmodule

`default_nettype wire

/* lsu/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  input  rv_pkg::ctrl_t      ctrl,
  input  rv_pkg::word_t      addr,
  input  rv_pkg::word_t      rs2_data,
  input  rv_pkg::word_t      dmem_rdata,
  output rv_pkg::byte_mask_t wmask,
  output rv_pkg::word_t      wdata,
  output rv_pkg::word_t      load_data
);

  logic [4:0]    lane_shift; // byte offset in bits
  rv_pkg::word_t rd_lane;

  assign lane_shift = {addr[1:0], 3'b000};

  always_comb begin
    wmask = '0;
    if (ctrl.mem_write) begin
      case (ctrl.funct3)
        rv_pkg::F3_B: wmask = 4'b0001 << addr[1:0];
        rv_pkg::F3_H: begin
          if (!addr[0]) wmask = addr[1] ? 4'b1100 : 4'b0011;
        end
        rv_pkg::F3_W: begin
          if (addr[1:0] == 2'b00) wmask = 4'b1111;
        end
        default: wmask = '0;
      endcase
    end
  end

  // low bytes of rs2 moved into the lanes the mask enables
  always_comb begin
    case (ctrl.funct3)
      rv_pkg::F3_B: wdata = {24'h0, rs2_data[7:0]} << lane_shift;
      rv_pkg::F3_H: wdata = {16'h0, rs2_data[15:0]} << lane_shift;
      default:      wdata = rs2_data;
    endcase
  end

  // addressed byte or half lands in the low bits
  assign rd_lane = dmem_rdata >> lane_shift;

  always_comb begin
    case (ctrl.funct3)
      rv_pkg::F3_B:  load_data = {{24{rd_lane[7]}}, rd_lane[7:0]};
      rv_pkg::F3_H:  load_data = {{16{rd_lane[15]}}, rd_lane[15:0]};
      rv_pkg::F3_W:  load_data = dmem_rdata;
      rv_pkg::F3_BU: load_data = {24'h0, rd_lane[7:0]};
      rv_pkg::F3_HU: load_data = {16'h0, rd_lane[15:0]};
      default:       load_data = '0;
    endcase
  end

  // misaligned half or word stores would leave the mask empty
  always_comb begin
    a_store_mask: assert final (!ctrl.mem_write || (wmask != '0))
      else $error("lsu: store to %h with empty byte mask", addr);
  end

endmodule

`default_nettype wire

/* src/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::word_t     inst,
  input  rv_pkg::word_t     dmem_rdata,
  output rv_pkg::word_t     pc,
  output rv_pkg::dmem_req_t dmem_req,
  output logic              halt
);

  rv_pkg::ctrl_t      ctrl;
  rv_pkg::reg_addr_t  rs1_addr;
  rv_pkg::reg_addr_t  rs2_addr;
  rv_pkg::reg_addr_t  rd_addr;
  rv_pkg::word_t      rs1_data;
  rv_pkg::word_t      rs2_data;
  rv_pkg::word_t      operand1;
  rv_pkg::word_t      addr_sum;
  rv_pkg::word_t      link_addr;
  rv_pkg::word_t      load_data;
  rv_pkg::word_t      wb_data;
  rv_pkg::byte_mask_t st_wmask;
  rv_pkg::word_t      st_wdata;

  decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  // lui reads x0 so the shared adder just passes the immediate
  assign rs1_addr = (inst[6:0] == rv_pkg::OPC_LUI) ? '0 : inst[19:15];
  assign rs2_addr = inst[24:20];
  assign rd_addr  = inst[11:7];

  reg_file u_reg_file (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .wen      (ctrl.reg_wen),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // one adder for addi, lui, auipc, jump targets and memory addresses
  assign operand1  = ctrl.src1_pc ? pc : rs1_data;
  assign addr_sum  = operand1 + ctrl.imm;
  assign link_addr = pc + rv_pkg::PC_STEP;

  pc_unit u_pc_unit (
    .clk         (clk),
    .reset       (reset),
    .pc_jump     (ctrl.pc_jump),
    .jump_target (addr_sum),
    .pc          (pc)
  );

  load_store_unit u_load_store_unit (
    .ctrl       (ctrl),
    .addr       (addr_sum),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .wmask      (st_wmask),
    .wdata      (st_wdata),
    .load_data  (load_data)
  );

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::WB_LINK: wb_data = link_addr;
      rv_pkg::WB_LOAD: wb_data = load_data;
      default:         wb_data = addr_sum;
    endcase
  end

  always_comb begin
    dmem_req.addr  = addr_sum;
    dmem_req.wdata = st_wdata;
    dmem_req.wmask = st_wmask;
    dmem_req.read  = ctrl.mem_read;  // level strobes, no handshake
    dmem_req.write = ctrl.mem_write;
  end

  assign halt = ctrl.halt;

endmodule

`default_nettype wire

/* dv/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::word_t     inst,
  input  rv_pkg::word_t     pc,
  input  rv_pkg::dmem_req_t dmem_req,
  input  rv_pkg::word_t     dmem_rdata,
  input  logic              halt,
  output int                errors,
  output int                checks,
  output logic              done
);

  typedef struct packed {
    rv_pkg::word_t      next_pc;
    rv_pkg::word_t      addr;
    rv_pkg::word_t      wdata;
    rv_pkg::byte_mask_t wmask;
    logic               read;
    logic               write;
    logic               halt;
    logic               wen;
    rv_pkg::reg_addr_t  rd;
    rv_pkg::word_t      wb;
  } expect_t;

  logic [31:0][31:0] regs; // shadow register file, x0 never written
  rv_pkg::word_t     spc;
  expect_t           want;

  function automatic expect_t ref_step(rv_pkg::word_t ins, rv_pkg::word_t cur_pc,
                                       logic [31:0][31:0] rf, rv_pkg::word_t rdata);
    expect_t       e;
    rv_pkg::word_t r1;
    rv_pkg::word_t r2;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t lane;
    r1    = rf[ins[19:15]];
    r2    = rf[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    e         = '0;
    e.next_pc = cur_pc + 4;
    e.rd      = ins[11:7];
    e.wen     = 1'b1;
    case (ins[6:0])
      rv_pkg::OPC_OP_IMM: e.wb = r1 + imm_i;
      rv_pkg::OPC_LUI:    e.wb = {ins[31:12], 12'h000};
      rv_pkg::OPC_AUIPC:  e.wb = cur_pc + {ins[31:12], 12'h000};
      rv_pkg::OPC_JAL: begin
        e.wb      = cur_pc + 4;
        e.next_pc = cur_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      rv_pkg::OPC_JALR: begin
        e.wb      = cur_pc + 4;
        e.next_pc = (r1 + imm_i) & ~32'd1;
      end
      rv_pkg::OPC_LOAD: begin
        e.addr = r1 + imm_i;
        e.read = 1'b1;
        lane   = rdata >> (e.addr[1:0] * 8);
        case (ins[14:12])
          3'd0:    e.wb = {{24{lane[7]}}, lane[7:0]};
          3'd1:    e.wb = {{16{lane[15]}}, lane[15:0]};
          3'd2:    e.wb = rdata;
          3'd4:    e.wb = {24'h0, lane[7:0]};
          3'd5:    e.wb = {16'h0, lane[15:0]};
          default: e.wb = '0;
        endcase
      end
      rv_pkg::OPC_STORE: begin
        e.wen   = 1'b0;
        e.addr  = r1 + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        e.write = 1'b1;
        case (ins[14:12])
          3'd0: begin
            e.wmask = 4'b0001 << e.addr[1:0];
            e.wdata = {24'h0, r2[7:0]} << (e.addr[1:0] * 8);
          end
          3'd1: begin
            e.wmask = 4'b0011 << e.addr[1:0];
            e.wdata = {16'h0, r2[15:0]} << (e.addr[1:0] * 8);
          end
          default: begin
            e.wmask = 4'b1111;
            e.wdata = r2;
          end
        endcase
      end
      rv_pkg::OPC_SYSTEM: begin
        e.wen  = 1'b0;
        e.halt = (ins == 32'h0010_0073);
      end
      default: e.wen = 1'b0;
    endcase
    return e;
  endfunction

  task automatic check(string name, rv_pkg::word_t expv, rv_pkg::word_t actv);
    checks++;
    if (expv !== actv) begin
      errors++;
      $display("FAILED %s at pc %h: expected %h actual %h", name, spc, expv, actv);
    end
  endtask

  initial begin
    errors = 0;
    checks = 0;
    done   = 1'b0;
  end

  always @(posedge clk) begin
    if (reset) begin
      spc  = rv_pkg::RESET_PC;
      regs = '0;
    end else if (!done) begin
      want = ref_step(inst, spc, regs, dmem_rdata);
      check("pc", spc, pc);
      check("halt", 32'(want.halt), 32'(halt));
      check("read", 32'(want.read), 32'(dmem_req.read));
      check("write", 32'(want.write), 32'(dmem_req.write));
      check("wmask", 32'(want.wmask), 32'(dmem_req.wmask));
      if (want.read || want.write) check("addr", want.addr, dmem_req.addr);
      if (want.write) check("wdata", want.wdata, dmem_req.wdata);
      if (want.wen && want.rd != '0) regs[want.rd] = want.wb;
      spc = want.next_pc;
      if (want.halt || halt) done <= 1'b1; // ebreak ends the run
    end
  end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int            PROG_LEN = 64;
  localparam int            SEED     = 75975;
  localparam rv_pkg::word_t NOP      = 32'h0000_0013; // addi x0, x0, 0

  logic              clk = 1'b0;
  logic              reset;
  rv_pkg::word_t     inst;
  rv_pkg::word_t     dmem_rdata;
  rv_pkg::word_t     pc;
  rv_pkg::dmem_req_t dmem_req;
  logic              halt;
  int                errors;
  int                checks;
  logic              done;
  int                fetch_errors = 0;
  rv_pkg::word_t     prog [PROG_LEN];
  rv_pkg::word_t     dmem [64];

  always #20 clk = ~clk;

  rv_core_top u_rv_core_top (.*);
  tb_checker  u_tb_checker (.*);

  // data window at 0x1000, 64 words
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dmem_req.write && dmem_req.wmask[b]) begin
        dmem[dmem_req.addr[7:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
      end
    end
  end

  function automatic rv_pkg::word_t i_type(rv_pkg::opcode_t opc, int rd, int f3, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic rv_pkg::word_t s_type(int f3, int rs1, int rs2, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_pkg::OPC_STORE};
  endfunction

  function automatic rv_pkg::word_t u_type(rv_pkg::opcode_t opc, int rd, int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic rv_pkg::word_t j_type(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::OPC_JAL};
  endfunction

  task automatic build_program();
    int i;
    int rd;
    int f3;
    int off;
    int skip;
    for (int s = 0; s < PROG_LEN; s++) begin
      prog[s[5:0]] = NOP;
    end
    prog[0] = u_type(rv_pkg::OPC_LUI, 7, 1); // x7 holds the data base
    // register file has no reset, give x1 to x6 known values first
    for (int r = 1; r < 7; r++) begin
      prog[r[5:0]] = i_type(rv_pkg::OPC_OP_IMM, r, 0, 0, $urandom());
    end
    i = 7;
    while (i < PROG_LEN - 1) begin
      rd   = $urandom_range(1, 6);
      skip = $urandom_range(0, 2);
      f3   = $urandom_range(0, 4);
      f3   = (f3 > 2) ? f3 + 1 : f3;  // b, h, w, bu, hu
      off  = $urandom_range(0, 255) & ~((1 << (f3 & 3)) - 1);
      case ($urandom_range(0, 9))
        0, 1: prog[i[5:0]] = i_type(rv_pkg::OPC_OP_IMM, rd, 0, $urandom_range(0, 6), $urandom());
        2:    prog[i[5:0]] = u_type(rv_pkg::OPC_LUI, rd, $urandom());
        3:    prog[i[5:0]] = u_type(rv_pkg::OPC_AUIPC, rd, $urandom());
        4, 5: prog[i[5:0]] = i_type(rv_pkg::OPC_LOAD, rd, f3, 7, off);
        6, 7: prog[i[5:0]] = s_type(f3 & 3, 7, $urandom_range(0, 7), off);
        8: if (i + 4 < PROG_LEN) begin
          prog[i[5:0]] = j_type(rd, 4 * (skip + 1)); // short forward jump
          i += skip;
        end
        9: if (i + 5 < PROG_LEN) begin
          prog[i[5:0]]  = u_type(rv_pkg::OPC_AUIPC, 6, 0);
          // odd offset now and then, jalr must clear bit 0
          prog[6'(i + 1)] = i_type(rv_pkg::OPC_JALR, rd, 0, 6, 8 + 4 * skip + $urandom_range(0, 1));
          i += skip + 1;
        end
        default: ;
      endcase
      i++;
    end
    prog[PROG_LEN - 1] = 32'h0010_0073; // ebreak
  endtask

  task automatic drive_inst();
    int idx;
    idx = int'((pc - rv_pkg::RESET_PC) >> 2);
    if (idx >= 0 && idx < PROG_LEN) begin
      inst = prog[idx[5:0]];
    end else begin
      fetch_errors++;
      $display("fetch from pc %h lies outside the program", pc);
      inst = NOP;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    foreach (dmem[a]) dmem[a] = $urandom();
    build_program();
    reset = 1'b1;
    inst  = NOP;  // keeps read, write and halt low in reset
    repeat (4) @(negedge clk);
    reset = 1'b0;
    forever begin
      drive_inst();
      @(negedge clk);
    end
  end

  initial begin
    wait (done === 1'b1);
    $display("closing: %0d check errors, %0d fetch errors, %0d checks", errors, fetch_errors, checks);
    if (errors == 0 && fetch_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // each instruction runs at most once, so three times the program is plenty
  initial begin
    #((PROG_LEN * 3 + 10) * 40);
    $display("timeout: ebreak never reached, %0d check errors so far", errors);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
common/rv_pkg.sv
src/decoder.sv
src/reg_file.sv
src/pc_unit.sv
lsu/load_store_unit.sv
src/rv_core_top.sv
dv/tb_checker.sv
dv/tb_top.sv

/* Makefile */
# Verilator simulation of the rv32 subset core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_top --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
